// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module procTb -f tb.f -o procSim

out=$(./obj_dir/procSim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF "TEST RESULT: PASS"; then
	exit 0
fi
exit 1

// ==== source/decodeStage.sv ====
// decode stage
// splits the instruction into fields, reads the register file
// with write-through from retire, and fills the decode/execute register

`timescale 1ns/1ps

module decodeStage (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic                             fetchValid,
	input  logic [procPkg::dataWidth-1:0]    fetchInstr,
	input  logic                             wrEn,
	input  logic [procPkg::regAddrWidth-1:0] wrReg,
	input  logic [procPkg::dataWidth-1:0]    wrData,
	output logic                             decValid,
	output procPkg::opcodeT                  decOp,
	output logic [procPkg::regAddrWidth-1:0] decRd,
	output logic [procPkg::regAddrWidth-1:0] decRs,
	output logic [procPkg::regAddrWidth-1:0] decRt,
	output logic [procPkg::dataWidth-1:0]    decRsVal,
	output logic [procPkg::dataWidth-1:0]    decRtVal,
	output logic [procPkg::dataWidth-1:0]    decImm
);
	import procPkg::*;

	logic [dataWidth-1:0] regFile [regCount];
	logic [regAddrWidth-1:0] rd;
	logic [regAddrWidth-1:0] rs;
	logic [regAddrWidth-1:0] rt;
	logic [dataWidth-1:0] rsVal;
	logic [dataWidth-1:0] rtVal;
	logic [dataWidth-1:0] imm;

	assign rd  = fetchInstr[11:9];
	assign rs  = fetchInstr[8:6];
	assign rt  = fetchInstr[5:3]; // only meaningful for register ops
	assign imm = {{(dataWidth-6){fetchInstr[5]}}, fetchInstr[5:0]};

	// a write retiring this cycle wins over the stored value
	assign rsVal = (wrEn && wrReg == rs) ? wrData : regFile[rs];
	assign rtVal = (wrEn && wrReg == rt) ? wrData : regFile[rt];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				regFile[i] <= '0;
			end
		end else if (wrEn) begin
			regFile[wrReg] <= wrData;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
			decOp    <= OP_NOP;
			decRd    <= '0;
			decRs    <= '0;
			decRt    <= '0;
			decRsVal <= '0;
			decRtVal <= '0;
			decImm   <= '0;
		end else begin
			decValid <= fetchValid;
			if (fetchValid) begin
				decOp    <= opcodeT'(fetchInstr[15:12]);
				decRd    <= rd;
				decRs    <= rs;
				decRt    <= rt;
				decRsVal <= rsVal;
				decRtVal <= rtVal;
				decImm   <= imm;
			end
		end
	end

endmodule

// ==== source/executeStage.sv ====
// execute stage
// forwards the retiring result into the operands, runs the ALU
// and fills the execute/retire register

`timescale 1ns/1ps

module executeStage (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic                             decValid,
	input  procPkg::opcodeT                  decOp,
	input  logic [procPkg::regAddrWidth-1:0] decRd,
	input  logic [procPkg::dataWidth-1:0]    decRsVal,
	input  logic [procPkg::dataWidth-1:0]    decRtVal,
	input  logic [procPkg::regAddrWidth-1:0] decRs,
	input  logic [procPkg::regAddrWidth-1:0] decRt,
	input  logic [procPkg::dataWidth-1:0]    decImm,
	input  logic                             retWrEn,
	input  logic [procPkg::regAddrWidth-1:0] retRd,
	input  logic [procPkg::dataWidth-1:0]    retResult,
	output logic                             exValid,
	output procPkg::opcodeT                  exOp,
	output logic [procPkg::regAddrWidth-1:0] exRd,
	output logic [procPkg::dataWidth-1:0]    exResult
);
	import procPkg::*;

	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] aluOut;

	// instruction one ahead is retiring now, take its result
	assign opA = (retWrEn && retRd == decRs) ? retResult : decRsVal;
	assign opB = (retWrEn && retRd == decRt) ? retResult : decRtVal;

	always_comb begin
		case (decOp)
			OP_ADD:  aluOut = opA + opB;
			OP_SUB:  aluOut = opA - opB;
			OP_AND:  aluOut = opA & opB;
			OP_XOR:  aluOut = opA ^ opB;
			OP_ADDI: aluOut = opA + decImm; // wraps mod 2^16
			default: aluOut = '0;           // nop, halt, illegal
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
			exOp    <= OP_NOP;
		end else begin
			exValid <= decValid;
			if (decValid)
				exOp <= decOp;
		end
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			exRd     <= decRd;
			exResult <= aluOut;
		end
	end

	// forwarding path must never feed an unresolved operand into a live result
	resultKnown: assert property (@(posedge clk) disable iff (!arstN)
		exValid |-> !$isunknown(exResult));

endmodule

// ==== source/fetchStage.sv ====
// fetch stage
// loadable instruction memory, program counter and fetch FSM

`timescale 1ns/1ps

module fetchStage #(
	parameter int imemAddrWidth = 6
) (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          run,
	input  logic                          loadEn,
	input  logic [imemAddrWidth-1:0]      loadAddr,
	input  logic [procPkg::dataWidth-1:0] loadData,
	output logic                          fetchValid,
	output logic [procPkg::dataWidth-1:0] fetchInstr
);
	import procPkg::*;

	logic [dataWidth-1:0] imem [2**imemAddrWidth];
	logic [imemAddrWidth-1:0] pc;
	fetchStateT fetchState;
	logic fetchNow;
	logic [dataWidth-1:0] nextWord;
	logic lastWord;

	// first word goes out the cycle after run rises
	assign fetchNow = (fetchState == FETCH_RUN) || (fetchState == FETCH_IDLE && run);
	assign nextWord = imem[pc];
	assign lastWord = (nextWord[15:12] == OP_HALT) || (&pc); // halt or top of memory

	always_ff @(posedge clk) begin
		if (loadEn)
			imem[loadAddr] <= loadData;
	end

	always_ff @(posedge clk) begin
		if (fetchNow)
			fetchInstr <= nextWord;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			fetchState <= FETCH_IDLE;
			pc         <= '0;
			fetchValid <= 1'b0;
		end else begin
			fetchValid <= fetchNow;
			if (fetchNow) begin
				pc         <= pc + 1'b1;
				fetchState <= lastWord ? FETCH_STOP : FETCH_RUN;
			end
		end
	end

	// program must be fully loaded before the core starts
	loadBeforeRun: assert property (@(posedge clk) disable iff (!arstN) !(loadEn && run));

endmodule

// ==== source/proc.sv ====
// 16-bit four-stage in-order processor
// fetch, decode with register file, execute with forwarding, retire

`timescale 1ns/1ps

module proc #(
	parameter int imemAddrWidth = 6
) (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic                             run,
	input  logic                             loadEn,
	input  logic [imemAddrWidth-1:0]         loadAddr,
	input  logic [procPkg::dataWidth-1:0]    loadData,
	output logic                             retireValid,
	output logic [procPkg::regAddrWidth-1:0] retireReg,
	output logic [procPkg::dataWidth-1:0]    retireData,
	output logic                             halted,
	output logic                             err
);
	import procPkg::*;

	logic fetchValid;
	logic [dataWidth-1:0] fetchInstr;

	logic decValid;
	opcodeT decOp;
	logic [regAddrWidth-1:0] decRd;
	logic [regAddrWidth-1:0] decRs;
	logic [regAddrWidth-1:0] decRt;
	logic [dataWidth-1:0] decRsVal;
	logic [dataWidth-1:0] decRtVal;
	logic [dataWidth-1:0] decImm;

	logic exValid;
	opcodeT exOp;
	logic [regAddrWidth-1:0] exRd;
	logic [dataWidth-1:0] exResult;

	// retire write port, also the forwarding source
	logic wrEn;
	logic [regAddrWidth-1:0] wrReg;
	logic [dataWidth-1:0] wrData;

	fetchStage #(
		.imemAddrWidth(imemAddrWidth)
	) i_fetch (
		.clk(clk), .arstN(arstN), .run(run), .loadEn(loadEn),
		.loadAddr(loadAddr), .loadData(loadData),
		.fetchValid(fetchValid), .fetchInstr(fetchInstr)
	);

	decodeStage i_decode (
		.clk(clk), .arstN(arstN), .fetchValid(fetchValid), .fetchInstr(fetchInstr),
		.wrEn(wrEn), .wrReg(wrReg), .wrData(wrData),
		.decValid(decValid), .decOp(decOp), .decRd(decRd), .decRs(decRs), .decRt(decRt),
		.decRsVal(decRsVal), .decRtVal(decRtVal), .decImm(decImm)
	);

	executeStage i_execute (
		.clk(clk), .arstN(arstN), .decValid(decValid), .decOp(decOp), .decRd(decRd),
		.decRsVal(decRsVal), .decRtVal(decRtVal), .decRs(decRs), .decRt(decRt),
		.decImm(decImm),
		.retWrEn(wrEn), .retRd(wrReg), .retResult(wrData),
		.exValid(exValid), .exOp(exOp), .exRd(exRd), .exResult(exResult)
	);

	retireStage i_retire (
		.clk(clk), .arstN(arstN), .exValid(exValid), .exOp(exOp), .exRd(exRd),
		.exResult(exResult),
		.wrEn(wrEn), .wrReg(wrReg), .wrData(wrData), .halted(halted), .err(err)
	);

	assign retireValid = wrEn;
	assign retireReg   = wrReg;
	assign retireData  = wrData;

endmodule

// ==== source/procPkg.sv ====
// shared definitions for the 16-bit in-order pipeline
// opcode and fetch state encodings, datapath widths

package procPkg;

	localparam int dataWidth    = 16; // register and instruction width
	localparam int regAddrWidth = 3;
	localparam int regCount     = 8;

	// opcode lives in instr[15:12]
	// codes not listed here are illegal and trap to err
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_XOR  = 4'd4,
		OP_ADDI = 4'd5,
		OP_HALT = 4'd15
	} opcodeT;

	typedef enum logic [1:0] {
		FETCH_IDLE = 2'd0, // waiting for run
		FETCH_RUN  = 2'd1,
		FETCH_STOP = 2'd2  // halt seen or pc wrapped
	} fetchStateT;

endpackage

// ==== source/retireStage.sv ====
// retire stage
// classifies the retiring op, drives the register write
// and keeps the sticky halt and error flags

`timescale 1ns/1ps

module retireStage (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic                             exValid,
	input  procPkg::opcodeT                  exOp,
	input  logic [procPkg::regAddrWidth-1:0] exRd,
	input  logic [procPkg::dataWidth-1:0]    exResult,
	output logic                             wrEn,
	output logic [procPkg::regAddrWidth-1:0] wrReg,
	output logic [procPkg::dataWidth-1:0]    wrData,
	output logic                             halted,
	output logic                             err
);
	import procPkg::*;

	logic isWrite;
	logic isHalt;
	logic isIllegal;
	logic haltSeen;
	logic errSeen;

	always_comb begin
		isWrite   = 1'b0;
		isHalt    = 1'b0;
		isIllegal = 1'b0;
		if (exValid) begin
			case (exOp)
				OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI: isWrite = 1'b1;
				OP_HALT: isHalt = 1'b1;
				OP_NOP:  ;
				default: isIllegal = 1'b1; // trapped, no write
			endcase
		end
	end

	assign wrEn   = isWrite;
	assign wrReg  = exRd;
	assign wrData = exResult;

	// flags show up in the retire cycle itself, then hold
	assign halted = haltSeen | isHalt;
	assign err    = errSeen | isIllegal;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			haltSeen <= 1'b0;
			errSeen  <= 1'b0;
		end else begin
			haltSeen <= halted;
			errSeen  <= err;
		end
	end

	// fetch stops at halt, so nothing younger may reach the register file
	noWriteAfterHalt: assert property (@(posedge clk) disable iff (!arstN) haltSeen |-> !wrEn);

endmodule

// ==== tb.f ====
source/procPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/retireStage.sv
source/proc.sv
verification/procChecker.sv
verification/procTb.sv

// ==== verification/procChecker.sv ====
// retire stream checker for the pipeline
// mirrors the loaded program, runs a reference model at run start
// and compares every retired write, the halt and the error flag

`timescale 1ns/1ps

module procChecker #(
	parameter int imemAddrWidth = 6
) (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic                             run,
	input  logic                             loadEn,
	input  logic [imemAddrWidth-1:0]         loadAddr,
	input  logic [procPkg::dataWidth-1:0]    loadData,
	input  logic                             retireValid,
	input  logic [procPkg::regAddrWidth-1:0] retireReg,
	input  logic [procPkg::dataWidth-1:0]    retireData,
	input  logic                             halted,
	input  logic                             err,
	input  logic                             testEnd,
	input  int                               testNum,
	output int                               passCount,
	output int                               failCount
);
	import procPkg::*;

	localparam int memWords = 2 ** imemAddrWidth;

	logic [dataWidth-1:0] mem [memWords]; // copy of what was loaded
	logic [regAddrWidth-1:0] expReg [$];
	logic [dataWidth-1:0] expData [$];
	logic expErr;
	logic expHalt;
	logic runQ;
	logic haltNoted;
	int writeIdx;
	int testErrors;

	// in-order execution of the program from all-zero registers
	function automatic void runReference();
		logic [dataWidth-1:0] regs [regCount];
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] imm;
		logic [dataWidth-1:0] res;
		logic [3:0] op;
		logic writes;
		expReg.delete();
		expData.delete();
		expErr  = 1'b0;
		expHalt = 1'b0;
		for (int r = 0; r < regCount; r++)
			regs[r] = '0;
		for (int pc = 0; pc < memWords; pc++) begin
			instr  = mem[pc];
			op     = instr[15:12];
			a      = regs[instr[8:6]];
			b      = regs[instr[5:3]];
			imm    = dataWidth'($signed(instr[5:0])); // signed 6-bit field
			res    = '0;
			writes = 1'b1;
			case (op)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_XOR:  res = a ^ b;
				OP_ADDI: res = a + imm;
				default: writes = 1'b0;
			endcase
			if (writes) begin
				regs[instr[11:9]] = res;
				expReg.push_back(instr[11:9]);
				expData.push_back(res);
			end else if (op == OP_HALT) begin
				expHalt = 1'b1;
				break;
			end else if (op != OP_NOP) begin
				expErr = 1'b1; // trapped, nothing written
			end
		end
	endfunction

	task automatic compareWrite();
		if (haltNoted || halted) begin
			$display("test %0d: write to r%0d retired after halt", testNum, retireReg);
			testErrors++;
		end else if (writeIdx >= expData.size()) begin
			$display("test %0d: unexpected write to r%0d beyond the %0d expected",
				testNum, retireReg, expData.size());
			testErrors++;
		end else begin
			if (retireReg !== expReg[writeIdx]) begin
				$display("mismatch at %0t: retireReg expected %0d got %0d",
					$time, expReg[writeIdx], retireReg);
				testErrors++;
			end
			if (retireData !== expData[writeIdx]) begin
				$display("mismatch at %0t: retireData expected %h got %h",
					$time, expData[writeIdx], retireData);
				testErrors++;
			end
		end
		writeIdx++;
	endtask

	task automatic finishTest();
		if (halted !== expHalt) begin
			$display("mismatch at %0t: halted expected %0b got %0b", $time, expHalt, halted);
			testErrors++;
		end
		if (err !== expErr) begin
			$display("mismatch at %0t: err expected %0b got %0b", $time, expErr, err);
			testErrors++;
		end
		if (writeIdx < expData.size()) begin
			$display("test %0d: only %0d of %0d expected writes retired",
				testNum, writeIdx, expData.size());
			testErrors++;
		end
		if (testErrors == 0) begin
			passCount++;
			$display("test %0d passed, %0d writes checked", testNum, writeIdx);
		end else begin
			failCount++;
			$display("test %0d failed with %0d errors", testNum, testErrors);
		end
	endtask

	initial begin
		passCount = 0;
		failCount = 0;
		expErr    = 1'b0;
		expHalt   = 1'b0;
	end

	always @(posedge clk) begin
		if (loadEn)
			mem[loadAddr] = loadData;
		if (!arstN) begin
			runQ       = 1'b0;
			haltNoted  = 1'b0;
			writeIdx   = 0;
			testErrors = 0;
		end else begin
			if (run && !runQ)
				runReference(); // program is complete once run rises
			runQ = run;
			if (retireValid)
				compareWrite();
			if (halted && !haltNoted) begin
				haltNoted = 1'b1;
				if (writeIdx != expData.size()) begin
					$display("test %0d: halted rose with %0d of %0d writes retired",
						testNum, writeIdx, expData.size());
					testErrors++;
				end
			end
			if (testEnd)
				finishTest();
		end
	end

endmodule

// ==== verification/procTb.sv ====
// testbench for the four-stage processor
// builds directed and LFSR programs, loads them, runs each to halt

`timescale 1ns/1ps

module procTb;
	import procPkg::*;

	localparam int imemAw   = 6;
	localparam int numTests = 7;
	localparam logic [dataWidth-1:0] haltWord = {OP_HALT, 12'h000};

	logic clk = 1'b0;
	logic arstN;
	logic run;
	logic loadEn;
	logic [imemAw-1:0] loadAddr;
	logic [dataWidth-1:0] loadData;
	logic retireValid;
	logic [regAddrWidth-1:0] retireReg;
	logic [dataWidth-1:0] retireData;
	logic halted;
	logic err;
	logic testEnd;
	int testNum;
	int passCount;
	int failCount;
	logic [15:0] lfsrState = 16'd651;
	logic [dataWidth-1:0] prog [$];

	proc #(.imemAddrWidth(imemAw)) i_dut (
		.clk(clk), .arstN(arstN), .run(run), .loadEn(loadEn),
		.loadAddr(loadAddr), .loadData(loadData),
		.retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
		.halted(halted), .err(err)
	);

	procChecker #(.imemAddrWidth(imemAw)) i_checker (
		.clk(clk), .arstN(arstN), .run(run), .loadEn(loadEn),
		.loadAddr(loadAddr), .loadData(loadData),
		.retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
		.halted(halted), .err(err), .testEnd(testEnd), .testNum(testNum),
		.passCount(passCount), .failCount(failCount)
	);

	always #20 clk = ~clk;

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // galois taps 16 14 13 11
	endfunction

	function automatic int takeBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | lfsrState[0];
			lfsrState = lfsrNext(lfsrState);
		end
		return v;
	endfunction

	function automatic logic [15:0] encodeReg(input logic [3:0] op, input int rd,
		input int rs, input int rt);
		return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
	endfunction

	function automatic logic [15:0] encodeImm(input int rd, input int rs, input int imm);
		return {OP_ADDI, rd[2:0], rs[2:0], imm[5:0]};
	endfunction

	// 40 legal ALU ops, then halt
	task automatic buildRandom();
		int op;
		prog.delete();
		repeat (40) begin
			op = (takeBits(3) % 5) + 1; // add, sub, and, xor, addi
			if (op == OP_ADDI)
				prog.push_back(encodeImm(takeBits(3), takeBits(3), takeBits(6)));
			else
				prog.push_back(encodeReg(4'(op), takeBits(3), takeBits(3), takeBits(3)));
		end
		prog.push_back(haltWord);
	endtask

	task automatic applyReset();
		@(negedge clk);
		arstN  = 1'b0;
		run    = 1'b0;
		loadEn = 1'b0;
		repeat (4) @(negedge clk);
		arstN = 1'b1;
	endtask

	task automatic runProgram(input int n);
		testNum = n;
		applyReset();
		for (int i = 0; i < prog.size(); i++) begin
			@(negedge clk);
			loadEn   = 1'b1;
			loadAddr = imemAw'(i);
			loadData = prog[i];
		end
		@(negedge clk);
		loadEn = 1'b0;
		run    = 1'b1;
		while (!halted)
			@(negedge clk);
		repeat (4) @(negedge clk); // window for stray retires
		testEnd = 1'b1;
		@(negedge clk);
		testEnd = 1'b0;
	endtask

	initial begin
		arstN    = 1'b0;
		run      = 1'b0;
		loadEn   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		testEnd  = 1'b0;
		testNum  = 0;
		// each op reads the result one back and two back
		prog = '{encodeImm(1, 0, 5), encodeImm(2, 0, -3), encodeReg(OP_ADD, 3, 1, 2),
			encodeReg(OP_SUB, 4, 3, 2), encodeReg(OP_XOR, 5, 4, 3),
			encodeReg(OP_AND, 6, 5, 4), encodeReg(OP_ADD, 7, 6, 5),
			encodeImm(1, 7, 1), haltWord};
		runProgram(1);
		for (int t = 0; t < 3; t++) begin
			buildRandom();
			runProgram(2 + t);
		end
		prog = '{encodeImm(1, 0, -32), encodeImm(1, 1, -1), encodeImm(2, 1, -17),
			encodeImm(3, 0, 31), encodeImm(3, 3, -32), encodeImm(4, 2, -5), haltWord};
		runProgram(5);
		// words behind halt must never retire
		prog = '{encodeImm(1, 0, 7), encodeReg(OP_ADD, 2, 1, 1), haltWord,
			encodeImm(3, 0, 1), encodeImm(4, 0, 2), encodeReg(OP_ADD, 5, 1, 1)};
		runProgram(6);
		prog = '{encodeImm(1, 0, 9), encodeImm(2, 1, 3), encodeReg(4'd7, 3, 1, 2),
			encodeReg(OP_ADD, 3, 1, 2), 16'h0000, encodeReg(OP_SUB, 4, 3, 1), haltWord};
		runProgram(7);
		@(negedge clk);
		$display("%0d tests run, %0d passed, %0d failed", numTests, passCount, failCount);
		if (passCount == numTests && failCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		#(numTests * (64 + 20) * 40);
		$display("watchdog expired before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
